/* logic/exu_cfg.svh */
// size macros for the load/store tracking block, include before any use of the sizes
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// ===========================================================================
// outstanding instruction tracking
// ===========================================================================

// number of OITF slots, one per outstanding load/store
`define EXU_OITF_DEPTH 4

// slot index width, must cover EXU_OITF_DEPTH
`define EXU_ITAG_WIDTH 2

// ===========================================================================
// register file view
// ===========================================================================

// 32 integer registers
`define EXU_RFIDX_WIDTH 5

`define EXU_XLEN 32

`endif

/* logic/exu_pkg.sv */
// shared struct types of the load/store tracking block, referenced by exu_pkg:: names
`default_nettype none

`include "exu_cfg.svh"

package exu_pkg;

    // slot index handed out at dispatch
    typedef logic [`EXU_ITAG_WIDTH-1:0] itag_t;

    typedef logic [`EXU_RFIDX_WIDTH-1:0] rfidx_t;

    // instruction seen by dispatch, register fields only
    typedef struct packed {
        logic   rs1en;
        logic   rs2en;
        logic   rdwen;
        rfidx_t rs1idx;
        rfidx_t rs2idx;
        rfidx_t rdidx;
    } disp_info_t;

    // what one OITF slot remembers
    typedef struct packed {
        logic   rdwen;
        rfidx_t rdidx;
    } alloc_t;

    // completion returned by the memory side, any order
    typedef struct packed {
        itag_t                itag;
        logic [`EXU_XLEN-1:0] wdata;
    } cmpl_t;

    // in-order register write
    typedef struct packed {
        rfidx_t               rdidx;
        logic [`EXU_XLEN-1:0] wdata;
    } wb_t;

endpackage

`default_nettype wire

/* logic/oitf_entry.sv */
// single OITF slot with its destination and the three hazard compares, one per slot in exu_oitf
`default_nettype none

module oitf_entry (
    input  logic                clk,
    input  logic                rst,
    input  logic                set,
    input  logic                clr,
    input  exu_pkg::alloc_t     alloc,
    input  exu_pkg::disp_info_t disp_info,
    output logic                vld,
    output exu_pkg::alloc_t     info,
    output logic                match_rs1,
    output logic                match_rs2,
    output logic                match_rd
);

    logic dst_live;

    // set has priority, a fresh allocation beats a stale clear
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= 1'b0;
        end else if (set) begin
            vld <= 1'b1;
        end else if (clr) begin
            vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (set) begin
            info <= alloc;
        end
    end

    // only a pending register write can cause a hazard
    assign dst_live = vld & info.rdwen;

    // RAW on either source
    assign match_rs1 = dst_live & disp_info.rs1en & (info.rdidx == disp_info.rs1idx);
    assign match_rs2 = dst_live & disp_info.rs2en & (info.rdidx == disp_info.rs2idx);

    // WAW on the destination
    assign match_rd = dst_live & disp_info.rdwen & (info.rdidx == disp_info.rdidx);

    // allocation pointer must never land on a live slot
    a_no_set_on_live: assert property (@(posedge clk) disable iff (rst) set |-> !vld)
        else $error("oitf_entry: slot allocated while still outstanding");

endmodule

`default_nettype wire

/* logic/exu_oitf.sv */
// outstanding instruction track FIFO, allocates itags at dispatch and frees them at retirement
`default_nettype none

`include "exu_cfg.svh"

module exu_oitf (
    input  logic                clk,
    input  logic                rst,
    input  logic                alloc_ena,
    input  exu_pkg::alloc_t     alloc,
    input  exu_pkg::disp_info_t disp_info,
    input  logic                ret_ena,
    output exu_pkg::itag_t      dis_ptr,
    output exu_pkg::itag_t      ret_ptr,
    output exu_pkg::alloc_t     ret_info,
    output logic                match_rs1,
    output logic                match_rs2,
    output logic                match_rd,
    output logic                oitf_full,
    output logic                oitf_empty
);

    exu_pkg::itag_t alc_idx;
    exu_pkg::itag_t ret_idx;
    logic           alc_flg;
    logic           ret_flg;
    logic           alc_wrap;
    logic           ret_wrap;

    logic [`EXU_OITF_DEPTH-1:0] slot_set;
    logic [`EXU_OITF_DEPTH-1:0] slot_clr;
    logic [`EXU_OITF_DEPTH-1:0] slot_vld;
    logic [`EXU_OITF_DEPTH-1:0] hit_rs1;
    logic [`EXU_OITF_DEPTH-1:0] hit_rs2;
    logic [`EXU_OITF_DEPTH-1:0] hit_rd;
    exu_pkg::alloc_t            slot_info [`EXU_OITF_DEPTH];

    // ========================================================================
    // pointers, the flag toggles on every wrap
    // ========================================================================

    assign alc_wrap = (alc_idx == exu_pkg::itag_t'(`EXU_OITF_DEPTH - 1));
    assign ret_wrap = (ret_idx == exu_pkg::itag_t'(`EXU_OITF_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            alc_idx <= '0;
            alc_flg <= 1'b0;
        end else if (alloc_ena) begin
            if (alc_wrap) begin
                alc_idx <= '0;
                alc_flg <= ~alc_flg;
            end else begin
                alc_idx <= alc_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ret_idx <= '0;
            ret_flg <= 1'b0;
        end else if (ret_ena) begin
            if (ret_wrap) begin
                ret_idx <= '0;
                ret_flg <= ~ret_flg;
            end else begin
                ret_idx <= ret_idx + 1'b1;
            end
        end
    end

    // same index, flags tell empty from full
    assign oitf_empty = (alc_idx == ret_idx) & (alc_flg == ret_flg);
    assign oitf_full  = (alc_idx == ret_idx) & (alc_flg != ret_flg);

    assign dis_ptr = alc_idx;
    assign ret_ptr = ret_idx;

    // ========================================================================
    // slots
    // ========================================================================

    generate
        for (genvar i = 0; i < `EXU_OITF_DEPTH; i++) begin : g_slot
            assign slot_set[i] = alloc_ena & (alc_idx == exu_pkg::itag_t'(i));
            assign slot_clr[i] = ret_ena & (ret_idx == exu_pkg::itag_t'(i));

            oitf_entry u_entry (
                .clk       (clk),
                .rst       (rst),
                .set       (slot_set[i]),
                .clr       (slot_clr[i]),
                .alloc     (alloc),
                .disp_info (disp_info),
                .vld       (slot_vld[i]),
                .info      (slot_info[i]),
                .match_rs1 (hit_rs1[i]),
                .match_rs2 (hit_rs2[i]),
                .match_rd  (hit_rd[i])
            );
        end
    endgenerate

    // any live slot blocks the request
    assign match_rs1 = |hit_rs1;
    assign match_rs2 = |hit_rs2;
    assign match_rd  = |hit_rd;

    // head slot for the writeback buffer
    assign ret_info = slot_info[ret_idx];

    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc_ena |-> !oitf_full)
        else $error("exu_oitf: allocation while full");

    // retire request from the buffer must hit a live head
    a_no_ret_empty: assert property (@(posedge clk) disable iff (rst)
        ret_ena |-> (!oitf_empty && slot_vld[ret_idx]))
        else $error("exu_oitf: retirement with no outstanding head");

endmodule

`default_nettype wire

/* logic/exu_disp.sv */
// dispatch decision for long-pipe instructions, answers each request with accept or reject
`default_nettype none

module exu_disp (
    input  logic                clk,
    input  logic                rst,
    input  logic                disp_vld,
    input  exu_pkg::disp_info_t disp_info,
    input  logic                match_rs1,
    input  logic                match_rs2,
    input  logic                match_rd,
    input  logic                oitf_full,
    input  exu_pkg::itag_t      dis_ptr,
    output logic                alloc_ena,
    output exu_pkg::alloc_t     alloc,
    output logic                disp_ack,
    output logic                disp_accepted,
    output exu_pkg::itag_t      disp_itag
);

    logic hazard;
    logic accept;

    // RAW on a source or WAW on rd against anything outstanding
    assign hazard = match_rs1 | match_rs2 | match_rd;

    // a retiring head still counts, no bypass of full
    assign accept = disp_vld & ~hazard & ~oitf_full;

    assign alloc_ena   = accept;
    assign alloc.rdwen = disp_info.rdwen;
    assign alloc.rdidx = disp_info.rdidx;

    // ========================================================================
    // registered answer, one cycle after the request
    // ========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_ack      <= 1'b0;
            disp_accepted <= 1'b0;
        end else begin
            disp_ack      <= disp_vld;
            disp_accepted <= accept;
        end
    end

    // itag the allocation took, meaningful only with an accept
    always_ff @(posedge clk) begin
        disp_itag <= dis_ptr;
    end

endmodule

`default_nettype wire

/* logic/exu_longpwb.sv */
// long-pipe writeback buffer, collects out-of-order completions and retires them in itag order
`default_nettype none

`include "exu_cfg.svh"

module exu_longpwb (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmpl_vld,
    input  exu_pkg::cmpl_t  cmpl,
    input  exu_pkg::itag_t  ret_ptr,
    input  exu_pkg::alloc_t ret_info,
    input  logic            oitf_empty,
    output logic            ret_ena,
    output logic            wb_vld,
    output exu_pkg::wb_t    wb
);

    logic [`EXU_OITF_DEPTH-1:0] filled;
    logic [`EXU_XLEN-1:0]       data_r [`EXU_OITF_DEPTH];

    // ========================================================================
    // completion capture
    // ========================================================================

    // a completing slot is never the retiring one, both may write
    always_ff @(posedge clk) begin
        if (rst) begin
            filled <= '0;
        end else begin
            if (ret_ena) begin
                filled[ret_ptr] <= 1'b0;
            end
            if (cmpl_vld) begin
                filled[cmpl.itag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmpl_vld) begin
            data_r[cmpl.itag] <= cmpl.wdata;
        end
    end

    // ========================================================================
    // in-order retirement
    // ========================================================================

    // head must be live and its data back
    assign ret_ena = ~oitf_empty & filled[ret_ptr];

    // no rdwen means the slot is freed without a write
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_vld <= 1'b0;
        end else begin
            wb_vld <= ret_ena & ret_info.rdwen;
        end
    end

    always_ff @(posedge clk) begin
        if (ret_ena) begin
            wb.rdidx <= ret_info.rdidx;
            wb.wdata <= data_r[ret_ptr];
        end
    end

    // memory side must not complete the same itag twice
    a_no_double_cmpl: assert property (@(posedge clk) disable iff (rst)
        cmpl_vld |-> !filled[cmpl.itag])
        else $error("exu_longpwb: completion for an itag already filled");

endmodule

`default_nettype wire

/* logic/exu_lsu_track.sv */
// top of the load/store tracking block, wires dispatch, OITF and writeback buffer together
`default_nettype none

module exu_lsu_track (
    input  logic                clk,
    input  logic                rst,
    input  logic                disp_vld,
    input  exu_pkg::disp_info_t disp_info,
    output logic                disp_ack,
    output logic                disp_accepted,
    output exu_pkg::itag_t      disp_itag,
    input  logic                cmpl_vld,
    input  exu_pkg::cmpl_t      cmpl,
    output logic                wb_vld,
    output exu_pkg::wb_t        wb,
    output logic                oitf_empty
);

    // dispatch to OITF
    logic            alloc_ena;
    exu_pkg::alloc_t alloc;

    // OITF back to dispatch
    logic            match_rs1;
    logic            match_rs2;
    logic            match_rd;
    logic            oitf_full;
    exu_pkg::itag_t  dis_ptr;

    // retire path
    logic            ret_ena;
    exu_pkg::itag_t  ret_ptr;
    exu_pkg::alloc_t ret_info;

    exu_disp u_exu_disp (
        .clk           (clk),
        .rst           (rst),
        .disp_vld      (disp_vld),
        .disp_info     (disp_info),
        .match_rs1     (match_rs1),
        .match_rs2     (match_rs2),
        .match_rd      (match_rd),
        .oitf_full     (oitf_full),
        .dis_ptr       (dis_ptr),
        .alloc_ena     (alloc_ena),
        .alloc         (alloc),
        .disp_ack      (disp_ack),
        .disp_accepted (disp_accepted),
        .disp_itag     (disp_itag)
    );

    exu_oitf u_exu_oitf (
        .clk        (clk),
        .rst        (rst),
        .alloc_ena  (alloc_ena),
        .alloc      (alloc),
        .disp_info  (disp_info),
        .ret_ena    (ret_ena),
        .dis_ptr    (dis_ptr),
        .ret_ptr    (ret_ptr),
        .ret_info   (ret_info),
        .match_rs1  (match_rs1),
        .match_rs2  (match_rs2),
        .match_rd   (match_rd),
        .oitf_full  (oitf_full),
        .oitf_empty (oitf_empty)
    );

    exu_longpwb u_exu_longpwb (
        .clk        (clk),
        .rst        (rst),
        .cmpl_vld   (cmpl_vld),
        .cmpl       (cmpl),
        .ret_ptr    (ret_ptr),
        .ret_info   (ret_info),
        .oitf_empty (oitf_empty),
        .ret_ena    (ret_ena),
        .wb_vld     (wb_vld),
        .wb         (wb)
    );

endmodule

`default_nettype wire

/* verification/tb_exu_lsu_track.sv */
// self-checking testbench driving random dispatch and out-of-order completions into exu_lsu_track
`default_nettype none

`include "exu_cfg.svh"

module tb_exu_lsu_track;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQ     = 400;
    localparam int TIMEOUT_CYC = NUM_REQ * 20;

    // one outstanding instruction as the model sees it
    typedef struct packed {
        exu_pkg::itag_t       itag;
        logic                 rdwen;
        exu_pkg::rfidx_t      rdidx;
        logic                 done;
        logic [`EXU_XLEN-1:0] data;
    } ent_t;

    // what the DUT must show in the next cycle
    typedef struct packed {
        logic           ack;
        logic           acc;
        exu_pkg::itag_t itag;
        logic           wb_vld;
        exu_pkg::wb_t   wb;
    } expect_t;

    logic                clk;
    logic                rst;
    logic                disp_vld;
    exu_pkg::disp_info_t disp_info;
    logic                disp_ack;
    logic                disp_accepted;
    exu_pkg::itag_t      disp_itag;
    logic                cmpl_vld;
    exu_pkg::cmpl_t      cmpl;
    logic                wb_vld;
    exu_pkg::wb_t        wb;
    logic                oitf_empty;

    ent_t           model_q [$];
    int             pend [$];
    expect_t        expected;
    exu_pkg::itag_t next_itag;
    int unsigned    cyc_cnt;
    int unsigned    wb_seen;
    int unsigned    wb_total;

    exu_lsu_track u_exu_lsu_track (
        .clk           (clk),
        .rst           (rst),
        .disp_vld      (disp_vld),
        .disp_info     (disp_info),
        .disp_ack      (disp_ack),
        .disp_accepted (disp_accepted),
        .disp_itag     (disp_itag),
        .cmpl_vld      (cmpl_vld),
        .cmpl          (cmpl),
        .wb_vld        (wb_vld),
        .wb            (wb),
        .oitf_empty    (oitf_empty)
    );

    always #2 clk = ~clk;

    task automatic compare_val(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // accept unless RAW/WAW against the model or all slots taken
    function automatic logic ref_accept(exu_pkg::disp_info_t d);
        logic hazard;
        hazard = 1'b0;
        foreach (model_q[k]) begin
            if (model_q[k].rdwen) begin
                if (d.rs1en && model_q[k].rdidx == d.rs1idx) begin
                    hazard = 1'b1;
                end
                if (d.rs2en && model_q[k].rdidx == d.rs2idx) begin
                    hazard = 1'b1;
                end
                if (d.rdwen && model_q[k].rdidx == d.rdidx) begin
                    hazard = 1'b1;
                end
            end
        end
        return !hazard && (model_q.size() < `EXU_OITF_DEPTH);
    endfunction

    // small index range keeps hazards frequent
    function automatic exu_pkg::disp_info_t rand_info();
        exu_pkg::disp_info_t d;
        d.rs1en  = ($urandom_range(0, 3) != 0);
        d.rs2en  = ($urandom_range(0, 1) != 0);
        d.rdwen  = ($urandom_range(0, 4) != 0);
        d.rs1idx = exu_pkg::rfidx_t'($urandom_range(0, 5));
        d.rs2idx = exu_pkg::rfidx_t'($urandom_range(0, 5));
        d.rdidx  = exu_pkg::rfidx_t'($urandom_range(0, 5));
        return d;
    endfunction

    // ========================================================================
    // memory side completing a random outstanding itag
    // ========================================================================

    always @(negedge clk) begin
        int idx;
        if (!rst && pend.size() != 0 && $urandom_range(0, 2) == 0) begin
            idx        = $urandom_range(0, pend.size() - 1);
            cmpl_vld   = 1'b1;
            cmpl.itag  = exu_pkg::itag_t'(pend[idx]);
            cmpl.wdata = $urandom();
            pend.delete(idx);
        end else begin
            cmpl_vld = 1'b0;
        end
    end

    // ========================================================================
    // model and comparison at the rising edge
    // ========================================================================

    always @(posedge clk) begin
        ent_t head;
        ent_t tmp;
        logic acc;
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: the run hung and did not finish in %0d cycles", TIMEOUT_CYC);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
        if (rst) begin
            expected  = '0;
            next_itag = '0;
        end else begin
            // outputs registered at the previous edge
            compare_val("oitf_empty", oitf_empty, model_q.size() == 0);
            compare_val("disp_ack", disp_ack, expected.ack);
            if (expected.ack) begin
                compare_val("disp_accepted", disp_accepted, expected.acc);
            end
            if (expected.ack && expected.acc) begin
                compare_val("disp_itag", disp_itag, expected.itag);
            end
            compare_val("wb_vld", wb_vld, expected.wb_vld);
            if (wb_vld) begin
                wb_seen = wb_seen + 1;
                compare_val("wb.rdidx", wb.rdidx, expected.wb.rdidx);
                compare_val("wb.wdata", wb.wdata, expected.wb.wdata);
            end

            // decision sees a retiring head as still occupied
            acc          = disp_vld && ref_accept(disp_info);
            expected.ack  = disp_vld;
            expected.acc  = acc;
            expected.itag = next_itag;

            // in-order retirement of a completed head
            expected.wb_vld = 1'b0;
            if (model_q.size() != 0 && model_q[0].done) begin
                head              = model_q.pop_front();
                expected.wb_vld   = head.rdwen;
                expected.wb.rdidx = head.rdidx;
                expected.wb.wdata = head.data;
            end

            if (cmpl_vld) begin
                foreach (model_q[k]) begin
                    if (model_q[k].itag == cmpl.itag && !model_q[k].done) begin
                        tmp        = model_q[k];
                        tmp.done   = 1'b1;
                        tmp.data   = cmpl.wdata;
                        model_q[k] = tmp;
                    end
                end
            end

            if (acc) begin
                tmp       = '0;
                tmp.itag  = next_itag;
                tmp.rdwen = disp_info.rdwen;
                tmp.rdidx = disp_info.rdidx;
                model_q.push_back(tmp);
                pend.push_back(int'(next_itag));
                next_itag = next_itag + 1'b1;
                if (disp_info.rdwen) begin
                    wb_total = wb_total + 1;
                end
            end
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================

    initial begin
        int gap;
        void'($urandom(32'hf1e89d6a));
        clk       = 1'b0;
        rst       = 1'b1;
        disp_vld  = 1'b0;
        disp_info = '0;
        cmpl_vld  = 1'b0;
        cmpl      = '0;
        cyc_cnt   = 0;
        wb_seen   = 0;
        wb_total  = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // idle stretch, nothing may come out yet
        repeat (3) @(negedge clk);

        for (int n = 0; n < NUM_REQ; n++) begin
            @(negedge clk);
            disp_vld  = 1'b1;
            disp_info = rand_info();
            gap       = $urandom_range(0, 2);
            repeat (gap) begin
                @(negedge clk);
                disp_vld = 1'b0;
            end
        end
        @(negedge clk);
        disp_vld = 1'b0;

        // drain every outstanding entry
        while (model_q.size() != 0 || pend.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);

        compare_val("oitf_empty", oitf_empty, 1);
        compare_val("wb_count", wb_seen, wb_total);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/exu_pkg.sv
logic/oitf_entry.sv
logic/exu_oitf.sv
logic/exu_disp.sv
logic/exu_longpwb.sv
logic/exu_lsu_track.sv
verification/tb_exu_lsu_track.sv
